// File: logic/rv32_params.svh
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// first fetch address, low memory is left free
`define RV_PC_START 32'h0000_0100

// byte distance between sequential instructions
`define RV_INSTR_STEP 4

`endif

// File: logic/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

  // major opcodes kept by this core, anything else retires as a no-op
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_t;

  typedef enum logic [3:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM_READ,
    ST_WRITEBACK,
    ST_STORE,
    ST_BRANCH
  } core_state_t;

  typedef enum logic [1:0] {
    WB_ALU,     // result register
    WB_MEM,     // captured load word
    WB_PC_NEXT  // link value for jal
  } wb_sel_t;

endpackage

`default_nettype wire

// File: logic/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

interface decode_if;

  rv32_pkg::opcode_t          opcode;
  logic [`RV_REG_ADDR_W-1:0]  rd;
  logic [`RV_REG_ADDR_W-1:0]  rs1;
  logic [`RV_REG_ADDR_W-1:0]  rs2;
  logic [`RV_XLEN-1:0]        imm;       // sign-extended per format
  rv32_pkg::alu_op_t          alu_op;
  logic                       branch_ne; // 1 for bne, 0 for beq

  modport decoder (output opcode, rd, rs1, rs2, imm, alu_op, branch_ne);
  modport controller (input opcode, alu_op, branch_ne);
  modport datapath (input opcode, rd, rs1, rs2, imm, alu_op, branch_ne);

endinterface

`default_nettype wire

// File: logic/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

  logic              operand_load; // capture operands a and b
  logic              use_imm;      // operand b from immediate
  logic              result_load;  // capture alu output
  rv32_pkg::alu_op_t alu_op_sel;
  logic              reg_write;
  rv32_pkg::wb_sel_t wb_sel;
  logic              pc_load;
  logic              take_target;  // pc + imm instead of pc + 4

  modport controller (output operand_load, use_imm, result_load, alu_op_sel,
                      reg_write, wb_sel, pc_load, take_target);
  modport datapath (input operand_load, use_imm, result_load, alu_op_sel,
                    reg_write, wb_sel, pc_load, take_target);

endinterface

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module instr_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                capture,
  input  logic [`RV_XLEN-1:0] mem_rd_data,
  decode_if.decoder           dec
);

  logic [`RV_XLEN-1:0] ir;
  logic [2:0]          funct3;
  logic                funct7_b5;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0; // opcode 0 decodes as a no-op
    end else if (capture) begin
      ir <= mem_rd_data;
    end
  end

  assign funct3    = ir[14:12];
  assign funct7_b5 = ir[30];

  // immediate formats
  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};

  assign dec.opcode    = rv32_pkg::opcode_t'(ir[6:0]);
  assign dec.rd        = ir[11:7];
  assign dec.rs2       = ir[24:20];
  assign dec.branch_ne = funct3[0];

  // lui and jal take x0 as operand a
  assign dec.rs1 = (dec.opcode == rv32_pkg::OPC_LUI || dec.opcode == rv32_pkg::OPC_JAL) ?
                   '0 : ir[19:15];

  always_comb begin
    case (dec.opcode)
      rv32_pkg::OPC_STORE:  dec.imm = imm_s;
      rv32_pkg::OPC_BRANCH: dec.imm = imm_b;
      rv32_pkg::OPC_JAL:    dec.imm = imm_j;
      rv32_pkg::OPC_LUI:    dec.imm = imm_u;
      default:              dec.imm = imm_i; // op-imm and load
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: begin
        // only register ops carry sub in funct7
        dec.alu_op = (dec.opcode == rv32_pkg::OPC_OP && funct7_b5) ?
                     rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      end
      3'b001:  dec.alu_op = rv32_pkg::ALU_SLL;
      3'b010:  dec.alu_op = rv32_pkg::ALU_SLT;
      3'b011:  dec.alu_op = rv32_pkg::ALU_SLTU;
      3'b100:  dec.alu_op = rv32_pkg::ALU_XOR;
      3'b101:  dec.alu_op = funct7_b5 ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      3'b110:  dec.alu_op = rv32_pkg::ALU_OR;
      default: dec.alu_op = rv32_pkg::ALU_AND;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/core_controller.sv
`timescale 1ns/1ps
`default_nettype none

module core_controller (
  input  logic          clk,
  input  logic          rst,
  input  logic          ena,
  decode_if.controller  dec,
  input  logic          zero,
  ctrl_if.controller    ctl,
  output logic          capture,
  output logic          addr_from_result,
  output logic          load_capture,
  output logic          store_pulse
);

  rv32_pkg::core_state_t state;
  rv32_pkg::core_state_t state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv32_pkg::ST_FETCH;
    end else if (ena) begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = rv32_pkg::ST_FETCH;
    case (state)
      rv32_pkg::ST_FETCH:  state_next = rv32_pkg::ST_DECODE;
      rv32_pkg::ST_DECODE: state_next = rv32_pkg::ST_EXEC;
      rv32_pkg::ST_EXEC: begin
        case (dec.opcode)
          rv32_pkg::OPC_OP,
          rv32_pkg::OPC_OP_IMM,
          rv32_pkg::OPC_LUI,
          rv32_pkg::OPC_JAL:   state_next = rv32_pkg::ST_WRITEBACK;
          rv32_pkg::OPC_LOAD:  state_next = rv32_pkg::ST_MEM_READ;
          rv32_pkg::OPC_STORE: state_next = rv32_pkg::ST_STORE;
          default:             state_next = rv32_pkg::ST_BRANCH; // unknown opcodes just step the pc
        endcase
      end
      rv32_pkg::ST_MEM_READ: state_next = rv32_pkg::ST_WRITEBACK;
      default:               state_next = rv32_pkg::ST_FETCH;
    endcase
  end

  always_comb begin
    capture          = 1'b0;
    addr_from_result = 1'b0;
    load_capture     = 1'b0;
    store_pulse      = 1'b0;
    ctl.operand_load = 1'b0;
    ctl.result_load  = 1'b0;
    ctl.reg_write    = 1'b0;
    ctl.pc_load      = 1'b0;
    ctl.take_target  = 1'b0;

    // operand b comes from the immediate for everything except register ops and branches
    ctl.use_imm = !(dec.opcode == rv32_pkg::OPC_OP || dec.opcode == rv32_pkg::OPC_BRANCH);

    case (dec.opcode)
      rv32_pkg::OPC_OP,
      rv32_pkg::OPC_OP_IMM: ctl.alu_op_sel = dec.alu_op;
      rv32_pkg::OPC_BRANCH: ctl.alu_op_sel = rv32_pkg::ALU_SUB; // compare by subtraction
      default:              ctl.alu_op_sel = rv32_pkg::ALU_ADD; // address and lui sum
    endcase

    case (dec.opcode)
      rv32_pkg::OPC_LOAD: ctl.wb_sel = rv32_pkg::WB_MEM;
      rv32_pkg::OPC_JAL:  ctl.wb_sel = rv32_pkg::WB_PC_NEXT;
      default:            ctl.wb_sel = rv32_pkg::WB_ALU;
    endcase

    case (state)
      rv32_pkg::ST_FETCH:  capture = ena;
      rv32_pkg::ST_DECODE: ctl.operand_load = ena;
      rv32_pkg::ST_EXEC:   ctl.result_load = ena;
      rv32_pkg::ST_MEM_READ: begin
        addr_from_result = 1'b1;
        load_capture     = ena;
      end
      rv32_pkg::ST_WRITEBACK: begin
        ctl.reg_write   = ena;
        ctl.pc_load     = ena;
        ctl.take_target = (dec.opcode == rv32_pkg::OPC_JAL);
      end
      rv32_pkg::ST_STORE: begin
        addr_from_result = 1'b1;
        store_pulse      = ena;
        ctl.pc_load      = ena;
      end
      rv32_pkg::ST_BRANCH: begin
        ctl.pc_load     = ena;
        ctl.take_target = (dec.opcode == rv32_pkg::OPC_BRANCH) && (zero != dec.branch_ne);
      end
      default: ;
    endcase
  end

  // a store never coincides with a register write
  a_store_no_wb: assert property (@(posedge clk) disable iff (rst)
    !(store_pulse && ctl.reg_write));

  // the write strobe is a single-cycle pulse, the fsm leaves ST_STORE right after
  a_store_one_cycle: assert property (@(posedge clk) disable iff (rst)
    store_pulse |=> !store_pulse);

endmodule

`default_nettype wire

// File: logic/exec_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module exec_datapath (
  input  logic                clk,
  input  logic                rst,
  decode_if.datapath          dec,
  ctrl_if.datapath            ctl,
  input  logic [`RV_XLEN-1:0] load_data,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] result,
  output logic [`RV_XLEN-1:0] rs2_value,
  output logic                zero
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
  logic [`RV_XLEN-1:0] rs1_rdata;
  logic [`RV_XLEN-1:0] rs2_rdata;
  logic [`RV_XLEN-1:0] wb_data;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;
  logic [4:0]          shamt;

  // x0 is cleared by reset and never written
  assign rs1_rdata = regs[dec.rs1];
  assign rs2_rdata = regs[dec.rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs[0] <= '0;
    end else if (ctl.reg_write && dec.rd != '0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.operand_load) begin
      op_a      <= rs1_rdata;
      op_b      <= ctl.use_imm ? dec.imm : rs2_rdata;
      rs2_value <= rs2_rdata; // kept for stores
    end
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (ctl.alu_op_sel)
      rv32_pkg::ALU_SUB:  alu_out = op_a - op_b;
      rv32_pkg::ALU_AND:  alu_out = op_a & op_b;
      rv32_pkg::ALU_OR:   alu_out = op_a | op_b;
      rv32_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      rv32_pkg::ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv32_pkg::ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      rv32_pkg::ALU_SLL:  alu_out = op_a << shamt;
      rv32_pkg::ALU_SRL:  alu_out = op_a >> shamt;
      rv32_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
      default:            alu_out = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctl.result_load) begin
      result <= alu_out;
    end
  end

  assign zero = (result == '0); // branch compare from the stored difference

  // pc and its two candidates
  assign pc_plus4  = pc + `RV_XLEN'(`RV_INSTR_STEP);
  assign pc_target = pc + dec.imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_PC_START;
    end else if (ctl.pc_load) begin
      pc <= ctl.take_target ? pc_target : pc_plus4;
    end
  end

  always_comb begin
    case (ctl.wb_sel)
      rv32_pkg::WB_MEM:     wb_data = load_data;
      rv32_pkg::WB_PC_NEXT: wb_data = pc_plus4; // link address
      default:              wb_data = result;
    endcase
  end

  // x0 reads zero on both ports
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (dec.rs1 != '0 || rs1_rdata == '0) && (dec.rs2 != '0 || rs2_rdata == '0));

endmodule

`default_nettype wire

// File: logic/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module mem_port (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] result,
  input  logic [`RV_XLEN-1:0] rs2_value,
  input  logic                addr_from_result,
  input  logic                load_capture,
  input  logic                store_pulse,
  input  logic [`RV_XLEN-1:0] mem_rd_data,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wr_data,
  output logic                mem_wr_ena,
  output logic [`RV_XLEN-1:0] load_data
);

  assign mem_addr   = addr_from_result ? result : pc; // data access or fetch
  assign mem_wr_ena = store_pulse;

  // tracks rs2 until the store cycle, then holds it on the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_data <= '0;
    end else if (!store_pulse) begin
      mem_wr_data <= rs2_value;
    end
  end

  always_ff @(posedge clk) begin
    if (load_capture) begin
      load_data <= mem_rd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv32_multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module rv32_multicycle_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                ena,         // low freezes the core
  input  logic [`RV_XLEN-1:0] mem_rd_data,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wr_data,
  output logic                mem_wr_ena,
  output logic [`RV_XLEN-1:0] pc
);

  logic                capture;
  logic                zero;
  logic                addr_from_result;
  logic                load_capture;
  logic                store_pulse;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] rs2_value;
  logic [`RV_XLEN-1:0] load_data;

  decode_if u_dec_if ();
  ctrl_if   u_ctl_if ();

  instr_decoder u_instr_decoder (
    .clk         (clk),
    .rst         (rst),
    .capture     (capture),
    .mem_rd_data (mem_rd_data),
    .dec         (u_dec_if.decoder)
  );

  core_controller u_core_controller (
    .clk              (clk),
    .rst              (rst),
    .ena              (ena),
    .dec              (u_dec_if.controller),
    .zero             (zero),
    .ctl              (u_ctl_if.controller),
    .capture          (capture),
    .addr_from_result (addr_from_result),
    .load_capture     (load_capture),
    .store_pulse      (store_pulse)
  );

  exec_datapath u_exec_datapath (
    .clk       (clk),
    .rst       (rst),
    .dec       (u_dec_if.datapath),
    .ctl       (u_ctl_if.datapath),
    .load_data (load_data),
    .pc        (pc),
    .result    (result),
    .rs2_value (rs2_value),
    .zero      (zero)
  );

  mem_port u_mem_port (
    .clk              (clk),
    .rst              (rst),
    .pc               (pc),
    .result           (result),
    .rs2_value        (rs2_value),
    .addr_from_result (addr_from_result),
    .load_capture     (load_capture),
    .store_pulse      (store_pulse),
    .mem_rd_data      (mem_rd_data),
    .mem_addr         (mem_addr),
    .mem_wr_data      (mem_wr_data),
    .mem_wr_ena       (mem_wr_ena),
    .load_data        (load_data)
  );

endmodule

`default_nettype wire

// File: dv/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module tb_memory (
  input  logic                clk,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] wr_data,
  input  logic                wr_ena,
  output logic [`RV_XLEN-1:0] rd_data
);

  logic [31:0] mem [256];
  int          wp;           // next program word
  logic [3:0]  reg_ops [10]; // funct7 bit 5 and funct3
  logic [14:0] imm_ops [9];  // funct3 and imm12

  function automatic logic [31:0] op_word(input logic [3:0] f, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    return {1'b0, f[3], 5'b0, rs2, rs1, f[2:0], rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] w);
    mem[wp] <= w;
    wp = wp + 1;
  endtask

  assign rd_data = mem[addr[9:2]]; // word addressed with a same-cycle read

  always @(posedge clk) begin
    if (wr_ena) begin
      mem[addr[9:2]] <= wr_data;
    end
  end

  initial begin
    reg_ops = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4, 4'h2, 4'h3, 4'h1, 4'h5, 4'hd};
    imm_ops = '{{3'b000, 12'h007}, {3'b111, 12'h03c}, {3'b110, 12'hf00},
                {3'b100, 12'h055}, {3'b010, 12'hfed}, {3'b011, 12'hfff},
                {3'b001, 12'h004}, {3'b101, 12'h01c}, {3'b101, 12'h402}};
    for (int i = 0; i < 256; i++) begin
      mem[i] <= {24'(i), 8'h00}; // opcode 0 retires as a no-op
    end
    mem[16] <= 32'hcafe_0123; // load source at 0x40
    wp = `RV_PC_START >> 2;
    put(imm_word(12'hfec, 5'd0, 3'b000, 5'd1, 7'b0010011)); // x1 = -20
    put(imm_word(12'h003, 5'd0, 3'b000, 5'd2, 7'b0010011)); // x2 = 3
    put(imm_word(12'h200, 5'd0, 3'b000, 5'd10, 7'b0010011)); // x10 = result base
    for (int k = 0; k < 10; k++) begin
      put(op_word(reg_ops[k], 5'd3, 5'd1, 5'd2));
      put(store_word(12'(4 * k), 5'd3, 5'd10));
    end
    for (int k = 0; k < 9; k++) begin
      put(imm_word(imm_ops[k][11:0], 5'd1, imm_ops[k][14:12], 5'd3, 7'b0010011));
      put(store_word(12'(40 + 4 * k), 5'd3, 5'd10));
    end
    put({20'habcde, 5'd3, 7'b0110111}); // lui x3
    put(store_word(12'd76, 5'd3, 5'd10));
    put(imm_word(12'h040, 5'd0, 3'b010, 5'd4, 7'b0000011)); // lw x4, 0x40(x0)
    put(store_word(12'd80, 5'd4, 5'd10));
    put(branch_word(13'd8, 5'd2, 5'd2, 3'b000)); // beq taken
    put(store_word(12'd84, 5'd1, 5'd10));        // skipped
    put(branch_word(13'd8, 5'd2, 5'd2, 3'b001)); // bne not taken
    put(store_word(12'd88, 5'd2, 5'd10));
    put(jump_word(21'd8, 5'd5));                 // jal x5 at 0x1c4
    put(store_word(12'd92, 5'd1, 5'd10));        // skipped
    put(store_word(12'd96, 5'd5, 5'd10));        // link value
    put(store_word(12'h1fc, 5'd2, 5'd10));       // marker store at 0x3fc
    put(jump_word(21'd0, 5'd0));                 // spin
  end

endmodule

`default_nettype wire

// File: dv/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_params.svh"

module core_tb;

  localparam int          timeout_cycles = 3000;
  localparam logic [31:0] opnd_a    = 32'hffff_ffec; // x1
  localparam logic [31:0] opnd_b    = 32'd3;         // x2
  localparam logic [31:0] res_base  = 32'h0000_0200; // x10
  localparam logic [31:0] marker    = 32'h0000_03fc;
  localparam logic [31:0] load_word = 32'hcafe_0123;
  localparam logic [31:0] jal_addr  = `RV_PC_START + 32'd196;
  localparam logic [31:0] skip_beq  = res_base + 32'd84;
  localparam logic [31:0] skip_jal  = res_base + 32'd92;

  logic                clk;
  logic                rst;
  logic                ena;
  logic [`RV_XLEN-1:0] mem_rd_data;
  logic [`RV_XLEN-1:0] mem_addr;
  logic [`RV_XLEN-1:0] mem_wr_data;
  logic                mem_wr_ena;
  logic [`RV_XLEN-1:0] pc;

  logic [31:0] exp_addr [32];
  logic [31:0] exp_data [32];
  logic [31:0] want_addr;
  logic [31:0] want_data;
  int          n_exp = 0;
  int          store_idx;
  int          err_count = 0;
  int          missing = 0;
  int          cycles;
  integer      seed = 32'h89849109;

  rv32_multicycle_core u_rv32_multicycle_core (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_ena  (mem_wr_ena),
    .pc          (pc)
  );

  tb_memory u_tb_memory (
    .clk     (clk),
    .addr    (mem_addr),
    .wr_data (mem_wr_data),
    .wr_ena  (mem_wr_ena),
    .rd_data (mem_rd_data)
  );

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] slot_addr(input int k);
    return res_base + 32'(4 * k);
  endfunction

  task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    n_exp = n_exp + 1;
  endtask

  // store sequence from rv32i semantics, in program order
  task automatic load_expected();
    add_store(slot_addr(0), opnd_a + opnd_b);
    add_store(slot_addr(1), opnd_a - opnd_b);
    add_store(slot_addr(2), opnd_a & opnd_b);
    add_store(slot_addr(3), opnd_a | opnd_b);
    add_store(slot_addr(4), opnd_a ^ opnd_b);
    add_store(slot_addr(5), {31'b0, $signed(opnd_a) < $signed(opnd_b)});
    add_store(slot_addr(6), {31'b0, opnd_a < opnd_b});
    add_store(slot_addr(7), opnd_a << opnd_b[4:0]);
    add_store(slot_addr(8), opnd_a >> opnd_b[4:0]);
    add_store(slot_addr(9), 32'($signed(opnd_a) >>> opnd_b[4:0]));
    add_store(slot_addr(10), opnd_a + sext12(12'h007));
    add_store(slot_addr(11), opnd_a & sext12(12'h03c));
    add_store(slot_addr(12), opnd_a | sext12(12'hf00));
    add_store(slot_addr(13), opnd_a ^ sext12(12'h055));
    add_store(slot_addr(14), {31'b0, $signed(opnd_a) < $signed(sext12(12'hfed))});
    add_store(slot_addr(15), {31'b0, opnd_a < sext12(12'hfff)});
    add_store(slot_addr(16), opnd_a << 4);
    add_store(slot_addr(17), opnd_a >> 28);
    add_store(slot_addr(18), 32'($signed(opnd_a) >>> 2));
    add_store(slot_addr(19), 32'habcd_e000);        // lui
    add_store(slot_addr(20), load_word);            // lw then sw
    add_store(slot_addr(22), opnd_b);               // after the not-taken bne
    add_store(slot_addr(24), jal_addr + 32'd4);     // jal link
    add_store(marker, opnd_b);
  endtask

  assign want_addr = exp_addr[store_idx];
  assign want_data = exp_data[store_idx];

  always @(posedge clk) begin
    if (rst) begin
      store_idx <= 0;
    end else if (mem_wr_ena && store_idx < n_exp) begin
      store_idx <= store_idx + 1;
    end
  end

  a_reset_state: assert property (@(posedge clk) $fell(rst) |->
    (pc == `RV_PC_START && mem_addr == `RV_PC_START && !mem_wr_ena))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: after reset pc %h mem_addr %h", $time, pc, mem_addr);
    end

  a_store_extra: assert property (@(posedge clk) disable iff (rst)
    mem_wr_ena |-> (store_idx < n_exp))
    else begin
      err_count = err_count + 1;
      $display("store seen after the whole expected sequence, at time %0t", $time);
    end

  a_store_addr: assert property (@(posedge clk) disable iff (rst)
    mem_wr_ena |-> (mem_addr == want_addr))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: store %0d to %h, expected %h", $time, store_idx, mem_addr, want_addr);
    end

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    mem_wr_ena |-> (mem_wr_data == want_data))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: store %0d data %h, expected %h", $time, store_idx, mem_wr_data,
               want_data);
    end

  // skipped-path stores must never show up
  a_store_skip: assert property (@(posedge clk) disable iff (rst)
    mem_wr_ena |-> !(mem_addr == skip_beq || mem_addr == skip_jal))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: store on a skipped path to %h", $time, mem_addr);
    end

  a_store_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_wr_ena |=> !mem_wr_ena)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: write strobe longer than one cycle", $time);
    end

  a_stall_no_write: assert property (@(posedge clk) disable iff (rst)
    !ena |-> !mem_wr_ena)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: write strobe high while ena is low", $time);
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    !ena |=> ($stable(pc) && $stable(mem_addr)))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: pc %h or mem_addr %h moved during a stall", $time, pc, mem_addr);
    end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // random stalls, roughly one cycle in four
  initial begin
    ena = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      ena = ($random(seed) & 3) != 0;
    end
  end

  initial begin
    rst = 1'b1;
    load_expected();
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    cycles = 0;
    while (store_idx < n_exp && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    repeat (2) @(posedge clk); // let the trailing checks complete
    if (store_idx < n_exp) begin
      missing = n_exp - store_idx;
      $display("timeout: only %0d of %0d stores seen after %0d cycles", store_idx, n_exp,
               cycles);
    end
    $display("errors: %0d failed checks, %0d missing stores", err_count, missing);
    if (err_count == 0 && missing == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/rv32_pkg.sv
logic/decode_if.sv
logic/ctrl_if.sv
logic/instr_decoder.sv
logic/core_controller.sv
logic/exec_datapath.sv
logic/mem_port.sv
logic/rv32_multicycle_core.sv
dv/tb_memory.sv
dv/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module core_tb -f sim.f -o core_tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/core_tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "test failed"; exit 1; } || echo "test passed"
